/* src/serdes_demo_pkg.sv */
`default_nettype none

package serdes_demo_pkg;

  // parallel bus sizes
  localparam int data_w   = 8;          // tx and rx data byte
  localparam int nibble_w = data_w / 2; // folded data field and status field

  // low counter bits that must all be set before a comma goes out
  localparam int comma_span_w = 8;      // comma every 256 counts

  // board sizes, used as parameter defaults
  localparam int default_lanes     = 2;
  localparam int default_ctr_w     = 31;
  localparam int default_hb_w      = 28; // heartbeat is bit hb_w-1 of the tx counter
  localparam int default_ldr_cnt_w = 20;

endpackage : serdes_demo_pkg

`default_nettype wire

/* src/tx_pattern_gen.sv */
`timescale 1ns/100ps
`default_nettype none

// free-running transmit pattern
// the top data_w bits of the counter go out as the tx byte
module tx_pattern_gen
  import serdes_demo_pkg::*;
#(
  parameter int ctr_w = default_ctr_w, // at least data_w + comma_span_w
  parameter int hb_w  = default_hb_w   // heartbeat tap, bit hb_w-1
) (
  input  logic              rx0_pclk,
  input  logic              arst_n,
  output logic [data_w-1:0] tx_data,  // counter top byte
  output logic              tx_comma, // one cycle per comma span
  output logic              tx_beat   // slow blink bit for the lane status
);

  logic [ctr_w-1:0] ctr;       // free-running pattern counter
  logic             span_full; // low span all ones, wraps to zero next clock

  assign span_full = &ctr[comma_span_w-1:0];

  always_ff @(posedge rx0_pclk or negedge arst_n) begin
    if (!arst_n) begin
      ctr      <= '0;
      tx_comma <= 1'b0;
    end else begin
      ctr <= ctr + ctr_w'(1);
      // registered one count early so the flag lines up with the
      // cycle where the low span reads zero
      // the zero count right out of reset never gets a comma
      tx_comma <= span_full;
    end
  end

  // byte taken from the top so it changes slowly on the wire
  assign tx_data = ctr[ctr_w-1 -: data_w];

  // heartbeat reported by every lane monitor
  assign tx_beat = ctr[hb_w-1];

endmodule : tx_pattern_gen

`default_nettype wire

/* src/lane_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

// per receive lane status
// tracks the low-speed LDR line, counts its rising edges and packs
// a status byte for the LED display
//
// status byte layout
//   [7:4] rx nibbles ORed together
//   [3]   loss of signal
//   [2]   CDR loss of lock
//   [1]   tx heartbeat
//   [0]   top bit of the LDR edge counter
module lane_monitor
  import serdes_demo_pkg::*;
#(
  parameter int ldr_cnt_w = default_ldr_cnt_w // edge counter width, wraps
) (
  input  logic              rx0_pclk,
  input  logic              arst_n,
  input  logic [data_w-1:0] rx_data,    // lane receive byte
  input  logic              rx_los,     // loss of signal
  input  logic              rx_lol,     // CDR loss of lock
  input  logic              rx_ldr,     // low-speed serial line, async to us
  input  logic              tx_beat,    // shared heartbeat from the generator
  output logic [data_w-1:0] lane_status
);

  logic [1:0]           ldr_trk;  // [1] newest sample, [0] previous one
  logic                 ldr_rise; // old low, new high
  logic [ldr_cnt_w-1:0] ldr_cnt;  // rising edges seen so far
  logic [nibble_w-1:0]  rx_hi;
  logic [nibble_w-1:0]  rx_lo;
  logic [nibble_w-1:0]  rx_fold;  // both nibbles squeezed into one
  logic [nibble_w-1:0]  flags;

  // LDR edge tracker
  // new sample enters at the top, the old one shifts down
  always_ff @(posedge rx0_pclk or negedge arst_n) begin
    if (!arst_n) begin
      ldr_trk <= 2'b00;
    end else begin
      ldr_trk <= {rx_ldr, ldr_trk[1]};
    end
  end

  assign ldr_rise = (ldr_trk == 2'b10); // visible one clock after the line rises

  // edge counter, bumps on the clock after the rise is seen
  always_ff @(posedge rx0_pclk or negedge arst_n) begin
    if (!arst_n) begin
      ldr_cnt <= '0;
    end else if (ldr_rise) begin
      ldr_cnt <= ldr_cnt + ldr_cnt_w'(1); // rolls over at full width
    end
  end

  // data fold
  assign rx_hi   = rx_data[data_w-1 -: nibble_w];
  assign rx_lo   = rx_data[nibble_w-1:0];
  assign rx_fold = rx_hi | rx_lo; // any set bit in either half shows up

  // low nibble of the display
  assign flags = {rx_los,               // bit 3
                  rx_lol,               // bit 2
                  tx_beat,              // bit 1
                  ldr_cnt[ldr_cnt_w-1]  // bit 0, blinks slowly with LDR traffic
                 };

  assign lane_status = {rx_fold, flags};

endmodule : lane_monitor

`default_nettype wire

/* src/led_select.sv */
`timescale 1ns/100ps
`default_nettype none

// picks one lane status byte for the LEDs
// out of range selects fall back to lane 0
module led_select
  import serdes_demo_pkg::*;
#(
  parameter  int num_lanes = default_lanes,
  localparam int sel_w     = (num_lanes > 1) ? $clog2(num_lanes) : 1
) (
  input  logic                        rx0_pclk,
  input  logic                        arst_n,
  input  logic [num_lanes*data_w-1:0] lane_status_all, // lane 0 in the low byte
  input  logic [sel_w-1:0]            lane_sel,
  output logic [data_w-1:0]           led
);

  logic [data_w-1:0] picked; // mux output ahead of the LED register

  always_comb begin
    picked = lane_status_all[data_w-1:0]; // lane 0 unless a valid lane matches
    for (int i = 1; i < num_lanes; i++) begin
      if (lane_sel == sel_w'(i)) begin
        picked = lane_status_all[i*data_w +: data_w];
      end
    end
  end

  // one clock of latency onto the pins
  always_ff @(posedge rx0_pclk or negedge arst_n) begin
    if (!arst_n) begin
      led <= '0;
    end else begin
      led <= picked;
    end
  end

endmodule : led_select

`default_nettype wire

/* src/serdes_demo_top.sv */
`timescale 1ns/100ps
`default_nettype none

// parallel side of the serdes bring-up demo
// tx pattern out, per-lane rx status in, one lane shown on the LEDs
// everything runs on the lane 0 receive clock
module serdes_demo_top
  import serdes_demo_pkg::*;
#(
  parameter  int num_lanes = default_lanes,
  parameter  int ctr_w     = default_ctr_w,
  parameter  int hb_w      = default_hb_w,
  parameter  int ldr_cnt_w = default_ldr_cnt_w,
  localparam int sel_w     = (num_lanes > 1) ? $clog2(num_lanes) : 1
) (
  input  logic                        rx0_pclk,
  input  logic                        arst_n,
  // receive lanes, lane 0 in the low bits
  input  logic [num_lanes*data_w-1:0] rx_data,
  input  logic [num_lanes-1:0]        rx_los,
  input  logic [num_lanes-1:0]        rx_lol,
  input  logic [num_lanes-1:0]        rx_ldr,
  input  logic [sel_w-1:0]            lane_sel, // LED lane choice
  // transmit side
  output logic [data_w-1:0]           tx_data,
  output logic                        tx_comma,
  output logic [data_w-1:0]           led
);

  logic                        tx_beat;         // heartbeat fanned out to all lanes
  logic [num_lanes*data_w-1:0] lane_status_all; // one status byte per lane

  // transmit pattern
  tx_pattern_gen #(
    .ctr_w (ctr_w),
    .hb_w  (hb_w)
  ) i_tx_pattern_gen (
    .rx0_pclk (rx0_pclk),
    .arst_n   (arst_n),
    .tx_data  (tx_data),
    .tx_comma (tx_comma),
    .tx_beat  (tx_beat)
  );

  // one monitor per lane
  for (genvar gi = 0; gi < num_lanes; gi++) begin : g_lane
    lane_monitor #(
      .ldr_cnt_w (ldr_cnt_w)
    ) i_lane_monitor (
      .rx0_pclk    (rx0_pclk),
      .arst_n      (arst_n),
      .rx_data     (rx_data[gi*data_w +: data_w]),
      .rx_los      (rx_los[gi]),
      .rx_lol      (rx_lol[gi]),
      .rx_ldr      (rx_ldr[gi]),
      .tx_beat     (tx_beat),
      .lane_status (lane_status_all[gi*data_w +: data_w])
    );
  end

  // LED mux and register
  led_select #(
    .num_lanes (num_lanes)
  ) i_led_select (
    .rx0_pclk        (rx0_pclk),
    .arst_n          (arst_n),
    .lane_status_all (lane_status_all),
    .lane_sel        (lane_sel),
    .led             (led)
  );

endmodule : serdes_demo_top

`default_nettype wire

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// byte compare, values shown in hex
task automatic check_byte(input string name, input logic [data_w-1:0] exp,
                          input logic [data_w-1:0] act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
  end
endtask

// outputs stay zero through reset and just after release
task automatic reset_values();
  repeat (reset_cycles) begin
    @(negedge rx0_pclk);
    check_byte("tx_data", '0, tx_data);
    check_bit("tx_comma", 1'b0, tx_comma);
    check_byte("led", '0, led);
  end
  arst_n = 1'b1; // release on a falling edge
  @(negedge rx0_pclk); // count 1, heartbeat and data still low
  check_byte("tx_data", '0, tx_data);
  check_bit("tx_comma", 1'b0, tx_comma);
  check_byte("led", '0, led);
endtask

// tx byte is the top of the count, comma on every nonzero multiple of 256
task automatic sweep_tx_pattern();
  logic [data_w-1:0] exp_data;
  logic              exp_comma;
  repeat (budget_tx) begin
    @(negedge rx0_pclk);
    exp_data  = model_cnt[ctr_w-1 -: data_w];
    exp_comma = (model_cnt[comma_span_w-1:0] == '0) && (model_cnt != '0);
    check_byte("tx_data", exp_data, tx_data);
    check_bit("tx_comma", exp_comma, tx_comma);
  end
endtask

// random bytes on every lane, led upper nibble shows the selected fold
task automatic fold_and_select();
  logic [data_w-1:0]   b;
  logic [data_w-1:0]   sel_byte;
  logic [nibble_w-1:0] exp_fold;
  sel_byte = '0;
  for (int s = 0; s < num_lanes; s++) begin
    for (int n = 0; n < fold_bytes; n++) begin
      for (int l = 0; l < num_lanes; l++) begin
        rand_byte(b);
        rx_data[l*data_w +: data_w] = b;
        if (l == s) sel_byte = b;
      end
      lane_sel = sel_w'(s);
      @(negedge rx0_pclk); // one register stage to led
      exp_fold = sel_byte[data_w-1 -: nibble_w] | sel_byte[nibble_w-1:0];
      check_byte("led[7:4]", data_w'(exp_fold), data_w'(led[data_w-1 -: nibble_w]));
    end
  end
endtask

// LOS and LOL per lane, other lanes get the opposite levels
task automatic status_flags();
  logic [31:0] prev_cnt; // count when the status was sampled
  rx_data = '0;
  for (int s = 0; s < num_lanes; s++) begin
    for (int c = 0; c < 4; c++) begin
      for (int l = 0; l < num_lanes; l++) begin
        rx_los[l] = (l == s) ? c[1] : ~c[1];
        rx_lol[l] = (l == s) ? c[0] : ~c[0];
      end
      lane_sel = sel_w'(s);
      repeat (flag_hold) begin
        @(negedge rx0_pclk);
        prev_cnt = model_cnt - 32'd1;
        check_bit("led[3]", c[1], led[3]);
        check_bit("led[2]", c[0], led[2]);
        check_bit("led[1]", prev_cnt[hb_w-1], led[1]); // heartbeat, one clock late
        check_bit("led[0]", 1'b0, led[0]);             // no LDR edges yet
      end
    end
  end
endtask

// pulses on lane 1 LDR, 3 high 3 low, then a held high level
task automatic count_ldr_edges();
  int                   edges;
  logic [ldr_cnt_w-1:0] wrapped; // edge count modulo 2^ldr_cnt_w
  edges    = 0;
  rx_los   = '0;
  rx_lol   = '0;
  lane_sel = sel_w'(1);
  for (int p = 0; p < ldr_pulses; p++) begin
    rx_ldr[1] = 1'b1;
    repeat (3) @(negedge rx0_pclk);
    rx_ldr[1] = 1'b0;
    repeat (3) @(negedge rx0_pclk); // edge counted and on led by now
    edges++;
    wrapped = ldr_cnt_w'(edges);
    check_bit("led[0]", wrapped[ldr_cnt_w-1], led[0]);
  end
  rx_ldr[1] = 1'b1; // last rise, then the level just sits
  edges++;
  wrapped = ldr_cnt_w'(edges);
  repeat (3) @(negedge rx0_pclk);
  repeat (ldr_hold) begin
    @(negedge rx0_pclk);
    check_bit("led[0]", wrapped[ldr_cnt_w-1], led[0]);
  end
  lane_sel = sel_w'(0); // lane 0 never saw an edge
  @(negedge rx0_pclk);
  check_bit("led[0]", 1'b0, led[0]);
endtask

`endif

/* tests/tb_serdes_demo.sv */
`timescale 1ns/100ps
`default_nettype none

// directed testbench for the serdes demo parallel side
// inputs change on the falling edge, outputs are read there too
module tb_serdes_demo
  import serdes_demo_pkg::*;
();

  // small DUT sizes so every counter wraps within a short run
  localparam int num_lanes = 2;
  localparam int ctr_w     = 16;
  localparam int hb_w      = 6;  // heartbeat is counter bit 5
  localparam int ldr_cnt_w = 4;  // edge counter top bit flips every 8 edges
  localparam int sel_w     = (num_lanes > 1) ? $clog2(num_lanes) : 1;

  // cycle budgets of the tests
  localparam int reset_cycles = 8;
  localparam int budget_reset = reset_cycles + 2;
  localparam int budget_tx    = 1024;
  localparam int fold_bytes   = 16;                        // random bytes per lane_sel
  localparam int budget_fold  = num_lanes * fold_bytes;
  localparam int flag_hold    = 10;                        // cycles per LOS/LOL combination
  localparam int budget_flags = num_lanes * 4 * flag_hold;
  localparam int ldr_pulses   = 25;                        // crosses the 16 wrap
  localparam int ldr_hold     = 20;
  localparam int budget_ldr   = ldr_pulses * 6 + ldr_hold + 4;
  localparam int cycle_limit  = budget_reset + budget_tx + budget_fold
                                + budget_flags + budget_ldr + 100; // plus margin

  logic                        rx0_pclk;
  logic                        arst_n;
  logic [num_lanes*data_w-1:0] rx_data;
  logic [num_lanes-1:0]        rx_los;
  logic [num_lanes-1:0]        rx_lol;
  logic [num_lanes-1:0]        rx_ldr;
  logic [sel_w-1:0]            lane_sel;
  logic [data_w-1:0]           tx_data;
  logic                        tx_comma;
  logic [data_w-1:0]           led;

  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt = 0;  // run length guard
  logic [31:0] model_cnt;      // expected tx counter value
  logic [31:0] lfsr_state;

  serdes_demo_top #(
    .num_lanes (num_lanes),
    .ctr_w     (ctr_w),
    .hb_w      (hb_w),
    .ldr_cnt_w (ldr_cnt_w)
  ) i_dut (
    .rx0_pclk (rx0_pclk),
    .arst_n   (arst_n),
    .rx_data  (rx_data),
    .rx_los   (rx_los),
    .rx_lol   (rx_lol),
    .rx_ldr   (rx_ldr),
    .lane_sel (lane_sel),
    .tx_data  (tx_data),
    .tx_comma (tx_comma),
    .led      (led)
  );

  initial rx0_pclk = 1'b0;
  always #10 rx0_pclk = ~rx0_pclk; // 20 ns period

  // cycles since reset release, zero until the first rising edge
  always @(posedge rx0_pclk or negedge arst_n) begin
    if (!arst_n) begin
      model_cnt <= '0;
    end else begin
      model_cnt <= model_cnt + 32'd1;
    end
  end

  always @(posedge rx0_pclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step for each bit taken
  task automatic rand_byte(output logic [data_w-1:0] b);
    b = '0;
    for (int i = 0; i < data_w; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[data_w-2:0], lfsr_state[0]};
    end
  endtask

  `include "tb_checks.svh"

  initial begin
    err_cnt    = 0;
    chk_cnt    = 0;
    lfsr_state = 32'd73002;
    arst_n     = 1'b0;
    rx_data    = '0;
    rx_los     = '0;
    rx_lol     = '0;
    rx_ldr     = '0;
    lane_sel   = '0;
    reset_values();
    sweep_tx_pattern();
    fold_and_select();
    status_flags();
    count_ldr_edges();
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_serdes_demo

`default_nettype wire

/* flist.f */
+incdir+tests
src/serdes_demo_pkg.sv
src/tx_pattern_gen.sv
src/lane_monitor.sv
src/led_select.sv
src/serdes_demo_top.sv
tests/tb_serdes_demo.sv

/* Makefile */
# Verilator build and run for the serdes demo testbench

VERILATOR ?= verilator
TOP       ?= tb_serdes_demo
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TB PASSED

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard tests/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
